// ==== design/fb_readout_defs.svh ====
`ifndef FB_READOUT_DEFS_SVH
`define FB_READOUT_DEFS_SVH

// ######################################################################
// Display geometry
// ######################################################################

`define FB_OUTPUT_WIDTH 64	// Pixels per display line
`define FB_OUTPUT_HEIGHT 4	// Lines per frame

// Crop window origin in the stored frame
`define FB_CROP_XOFFSET 16
`define FB_CROP_YOFFSET 8

// ######################################################################
// Memory side
// ######################################################################

`define FB_BURST_LEN 4	// Beats per AXI read burst

// 32-bit lanes per 256-bit beat with RGB in the upper 24 bits of a lane
`define FB_PIXELS_PER_BEAT 8

// One bank holds a full scale-mode source line of 128 pixels
`define FB_BANK_BEATS 16

`endif

// ==== design/fb_readout_pkg.sv ====
package fb_readout_pkg;

`include "fb_readout_defs.svh"

	localparam int BEAT_IDX_W = $clog2(`FB_BANK_BEATS);

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef logic [`FB_PIXELS_PER_BEAT*32-1:0] beat_t;
	typedef logic [28:0] axi_addr_t;	// Byte address
	typedef logic [11:0] line_num_t;
	typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

	typedef enum logic {
		ZOOM_SCALE = 1'b0,
		ZOOM_CROP = 1'b1
	} zoom_t;

	// AXI read address and read data
	typedef struct packed {
		logic valid;
		axi_addr_t addr;
	} ar_req_t;

	typedef struct packed {
		logic valid;
		logic last;
		beat_t data;
	} r_beat_t;

	// Scanout asks the fetcher for one line
	typedef struct packed {
		logic valid;	// Single cycle
		line_num_t line;
		logic bank;
	} line_req_t;

	typedef struct packed {
		logic en;
		logic bank;
		beat_idx_t beat;
		beat_t data;
	} lb_write_t;

	typedef struct packed {
		logic bank;
		beat_idx_t beat;
	} lb_read_t;

	typedef struct packed {
		logic valid;
		rgb_t rgb;
	} pixel_out_t;

endpackage

// ==== design/line_fetcher.sv ====
`timescale 1ns/100ps
`include "fb_readout_defs.svh"

module line_fetcher (
	input logic axi_clock,
	input logic global_reset,
	input fb_readout_pkg::zoom_t zoom,
	input fb_readout_pkg::line_req_t line_req,
	output fb_readout_pkg::ar_req_t ar,
	input logic arready,
	input fb_readout_pkg::r_beat_t r,
	output fb_readout_pkg::lb_write_t lb_write
);
	import fb_readout_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,	// arvalid high
		ST_DATA,	// Collecting beats
		ST_GAP		// One cycle after rlast
	} fetch_state_t;

	// Source pixels covered by one burst
	localparam logic [11:0] BURST_PIXELS = 12'(`FB_BURST_LEN * `FB_PIXELS_PER_BEAT);

	fetch_state_t state;
	line_num_t fetch_line;
	logic fetch_bank;
	logic [11:0] fetch_x;
	beat_idx_t fetch_beat;

	logic [11:0] line_end;
	logic [11:0] src_row;
	logic [11:0] src_col;
	logic req_accept;

	// Lines past the bottom of the display are dropped
	assign req_accept = (state == ST_IDLE) && line_req.valid &&
		(line_req.line < 12'(`FB_OUTPUT_HEIGHT));

	// ######################################################################
	// Address generation
	// ######################################################################

	always_comb begin
		if (zoom == ZOOM_CROP) begin
			src_row = fetch_line + 12'(`FB_CROP_YOFFSET);
			src_col = fetch_x + 12'(`FB_CROP_XOFFSET);
			line_end = 12'(`FB_OUTPUT_WIDTH);
		end else begin
			src_row = {fetch_line[10:0], 1'b0};	// Every second source row
			src_col = fetch_x;
			line_end = 12'(2 * `FB_OUTPUT_WIDTH);
		end
	end

	// Row pitch of 4096 pixels at 4 bytes per pixel
	always_comb begin
		ar.valid = (state == ST_ADDR);
		ar.addr = {3'b000, src_row, src_col, 2'b00};
	end

	// Beats go straight into the buffer since rready is tied high upstream
	always_comb begin
		lb_write.en = r.valid && (state == ST_DATA);
		lb_write.bank = fetch_bank;
		lb_write.beat = fetch_beat;
		lb_write.data = r.data;
	end

	// ######################################################################
	// Read burst FSM
	// ######################################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			state <= ST_IDLE;
			fetch_line <= '0;
			fetch_bank <= 1'b0;
			fetch_x <= '0;
			fetch_beat <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_accept) begin
						state <= ST_ADDR;
						fetch_line <= line_req.line;
						fetch_bank <= line_req.bank;
						fetch_x <= '0;
						fetch_beat <= '0;
					end
				end

				ST_ADDR: begin
					if (arready) begin
						state <= ST_DATA;
					end
				end

				ST_DATA: begin
					if (r.valid) begin
						fetch_beat <= beat_idx_t'(fetch_beat + 1'b1);
						if (r.last) begin
							fetch_x <= fetch_x + BURST_PIXELS;
							state <= ST_GAP;
						end
					end
				end

				ST_GAP: begin
					// Next burst or done with this line
					if (fetch_x < line_end) begin
						state <= ST_ADDR;
					end else begin
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// ######################################################################
	// Protocol checks
	// ######################################################################

	a_ar_hold: assert property (@(posedge axi_clock) disable iff (global_reset)
		ar.valid && !arready |=> ar.valid && $stable(ar.addr))
		else $error("ar dropped or changed before arready");

	a_r_idle: assert property (@(posedge axi_clock) disable iff (global_reset)
		r.valid |-> state != ST_IDLE)
		else $error("read beat with no burst outstanding");

	a_req_busy: assert property (@(posedge axi_clock) disable iff (global_reset)
		line_req.valid |-> state == ST_IDLE)
		else $error("line request during an active fetch");

endmodule

// ==== design/line_buffer.sv ====
`timescale 1ns/100ps
`include "fb_readout_defs.svh"

module line_buffer (
	input logic axi_clock,
	input fb_readout_pkg::lb_write_t lb_write,
	input fb_readout_pkg::lb_read_t lb_read,
	output fb_readout_pkg::beat_t rd_data
);
	import fb_readout_pkg::*;

	localparam int DEPTH = 2 * `FB_BANK_BEATS;

	// Bank select is the top address bit
	beat_t mem [DEPTH];

	logic [BEAT_IDX_W:0] wr_addr;
	logic [BEAT_IDX_W:0] rd_addr;

	assign wr_addr = {lb_write.bank, lb_write.beat};
	assign rd_addr = {lb_read.bank, lb_read.beat};

	always_ff @(posedge axi_clock) begin
		if (lb_write.en) begin
			mem[wr_addr] <= lb_write.data;
		end
	end

	// One cycle read latency
	always_ff @(posedge axi_clock) begin
		rd_data <= mem[rd_addr];
	end

	// Fetcher must fill the released bank, never the one on display
	a_bank_split: assert property (@(posedge axi_clock)
		lb_write.en |-> lb_write.bank != lb_read.bank)
		else $error("write into the bank being displayed");

endmodule

// ==== design/pixel_scanout.sv ====
`timescale 1ns/100ps
`include "fb_readout_defs.svh"

module pixel_scanout (
	input logic axi_clock,
	input logic global_reset,
	input logic frame_start,
	input logic line_start,
	input logic pixel_den,
	input fb_readout_pkg::zoom_t zoom,
	output fb_readout_pkg::line_req_t line_req,
	output fb_readout_pkg::lb_read_t lb_read,
	input fb_readout_pkg::beat_t rd_data,
	output fb_readout_pkg::pixel_out_t pixels
);
	import fb_readout_pkg::*;

	localparam int LANE_BITS = $clog2(`FB_PIXELS_PER_BEAT);

	typedef logic [LANE_BITS-1:0] lane_t;

	line_num_t disp_line;
	line_num_t next_line;
	logic disp_bank;
	logic [11:0] x;
	logic [11:0] x_step;

	lane_t lane_q;
	logic den_q;
	logic pix_valid;
	rgb_t pix_rgb;
	rgb_t pick_a;
	rgb_t pick_b;
	rgb_t next_rgb;

	// RGB sits in the upper 24 bits of each 32-bit lane
	function automatic rgb_t lane_pixel(beat_t beat, lane_t lane);
		return beat[int'(lane) * 32 + 8 +: 24];
	endfunction

	function automatic rgb_t rgb_avg(rgb_t a, rgb_t b);
		logic [8:0] sum_r;
		logic [8:0] sum_g;
		logic [8:0] sum_b;
		sum_r = a.red + b.red;
		sum_g = a.green + b.green;
		sum_b = a.blue + b.blue;
		return '{red: sum_r[8:1], green: sum_g[8:1], blue: sum_b[8:1]};	// Floor
	endfunction

	assign next_line = line_num_t'(disp_line + 1'b1);
	assign x_step = (zoom == ZOOM_CROP) ? 12'd1 : 12'd2;

	// ######################################################################
	// Line and bank control
	// ######################################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			disp_line <= '1;
			disp_bank <= 1'b1;
			x <= '0;
			line_req <= '0;
			den_q <= 1'b0;
			pix_valid <= 1'b0;
		end else begin
			line_req.valid <= 1'b0;
			if (frame_start) begin
				disp_line <= '1;	// First line_start wraps this to line 0
				disp_bank <= 1'b1;
				x <= '0;
				line_req <= '{valid: 1'b1, line: '0, bank: 1'b0};
			end else if (line_start) begin
				disp_line <= next_line;
				disp_bank <= ~disp_bank;
				x <= '0;
				// Refill the bank that just left the display
				line_req <= '{valid: 1'b1, line: line_num_t'(next_line + 1'b1),
					bank: disp_bank};
			end else if (pixel_den) begin
				x <= x + x_step;
			end
			den_q <= pixel_den;
			pix_valid <= den_q;
		end
	end

	// ######################################################################
	// Readout pipeline
	// ######################################################################

	assign lb_read = '{bank: disp_bank, beat: x[LANE_BITS +: BEAT_IDX_W]};

	// Lane position follows the buffer read by one stage
	always_ff @(posedge axi_clock) begin
		lane_q <= x[LANE_BITS-1:0];
		pix_rgb <= next_rgb;
	end

	always_comb begin
		pick_a = lane_pixel(rd_data, lane_q);
		pick_b = lane_pixel(rd_data, lane_q | lane_t'(1));	// Odd partner
		if (zoom == ZOOM_CROP) begin
			next_rgb = pick_a;
		end else begin
			next_rgb = rgb_avg(pick_a, pick_b);
		end
	end

	assign pixels = '{valid: pix_valid, rgb: pix_rgb};

	a_den_line: assert property (@(posedge axi_clock) disable iff (global_reset)
		!(pixel_den && line_start))
		else $error("pixel_den together with line_start");

endmodule

// ==== design/fb_readout.sv ====
`timescale 1ns/100ps

module fb_readout (
	input logic axi_clock,
	input logic global_reset,
	input logic frame_start,
	input logic line_start,
	input logic pixel_den,
	input logic arready,
	input fb_readout_pkg::zoom_t zoom,
	output fb_readout_pkg::ar_req_t ar,
	input fb_readout_pkg::r_beat_t r,
	output fb_readout_pkg::pixel_out_t pixels
);
	import fb_readout_pkg::*;

	line_req_t line_req;	// Scanout to fetcher
	lb_write_t lb_write;
	lb_read_t lb_read;
	beat_t rd_data;

	// AXI read side
	line_fetcher line_fetcher_inst (
		.axi_clock(axi_clock),
		.global_reset(global_reset),
		.zoom(zoom),
		.line_req(line_req),
		.ar(ar),
		.arready(arready),
		.r(r),
		.lb_write(lb_write)
	);

	line_buffer line_buffer_inst (
		.axi_clock(axi_clock),
		.lb_write(lb_write),
		.lb_read(lb_read),
		.rd_data(rd_data)
	);

	// Video side
	pixel_scanout pixel_scanout_inst (
		.axi_clock(axi_clock),
		.global_reset(global_reset),
		.frame_start(frame_start),
		.line_start(line_start),
		.pixel_den(pixel_den),
		.zoom(zoom),
		.line_req(line_req),
		.lb_read(lb_read),
		.rd_data(rd_data),
		.pixels(pixels)
	);

endmodule

// ==== test/fb_readout_tb.sv ====
`timescale 1ns/100ps
`include "fb_readout_defs.svh"

module fb_readout_tb;
	import fb_readout_pkg::*;

	localparam int BURST_PIX = `FB_BURST_LEN * `FB_PIXELS_PER_BEAT;
	localparam int FETCH_LIMIT = 2000;	// Cycles allowed per line fetch

	logic axi_clock;
	logic global_reset;
	logic frame_start;
	logic line_start;
	logic pixel_den;
	logic arready = 1'b0;
	zoom_t zoom;
	ar_req_t ar;
	r_beat_t r = '0;
	pixel_out_t pixels;

	string test_name = "reset";
	int cycle = 0;
	int bursts_done = 0;	// Bursts whose last beat has been sent
	logic stall_en = 1'b0;
	logic [31:0] lfsr_state = 32'd75980;
	axi_addr_t exp_addr_q[$];
	rgb_t exp_pix_q[$];
	int due_q[$];	// Cycle at which each pixel is due

	// Memory model state
	axi_addr_t burst_q[$];
	axi_addr_t burst_addr;
	int beat_idx = 0;
	int ar_delay = 0;
	logic burst_active = 1'b0;
	logic gap;

	fb_readout fb_readout_inst (.*);

	initial begin
		axi_clock = 1'b0;
		forever #5 axi_clock = ~axi_clock;
	end

	always @(posedge axi_clock) cycle <= cycle + 1;

	// ######################################################################
	// Helpers and reference model
	// ######################################################################

	task automatic abort_test(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_addr(input axi_addr_t expected, input axi_addr_t actual);
		if (actual !== expected) begin
			abort_test($sformatf("[ERROR] %s: read address expected 0x%h, actual 0x%h",
				test_name, expected, actual));
		end
	endtask

	task automatic compare_pixel(input rgb_t expected, input rgb_t actual);
		if (actual !== expected) begin
			abort_test($sformatf("[ERROR] %s: pixel expected 0x%h, actual 0x%h",
				test_name, expected, actual));
		end
	endtask

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end else begin
			return s >> 1;
		end
	endfunction

	function automatic logic [3:0] draw_bits(input int count);
		logic [3:0] val;
		val = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[2:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// Stored frame content as a hash of the pixel address
	function automatic rgb_t src_pixel(input logic [31:0] pix_addr);
		logic [31:0] h;
		h = pix_addr * 32'h9e37_79b1;
		h = h ^ (h >> 15);
		h = h * 32'h85eb_ca6b;
		h = h ^ (h >> 13);
		return h[23:0];
	endfunction

	function automatic beat_t build_beat(input axi_addr_t byte_addr, input int beat);
		beat_t data;
		logic [31:0] pix;
		for (int lane = 0; lane < `FB_PIXELS_PER_BEAT; lane++) begin
			pix = 32'(byte_addr >> 2) + beat * `FB_PIXELS_PER_BEAT + lane;
			data[lane * 32 +: 32] = {src_pixel(pix), pix[7:0] ^ 8'h5a};	// Padding byte
		end
		return data;
	endfunction

	function automatic axi_addr_t ref_addr(input zoom_t z, input int line, input int burst);
		int row;
		int col;
		row = (z == ZOOM_CROP) ? line + `FB_CROP_YOFFSET : 2 * line;
		col = burst * BURST_PIX + ((z == ZOOM_CROP) ? `FB_CROP_XOFFSET : 0);
		return axi_addr_t'((row * 4096 + col) * 4);
	endfunction

	function automatic rgb_t ref_pixel(input zoom_t z, input int line, input int x);
		rgb_t a;
		rgb_t b;
		rgb_t avg;
		if (z == ZOOM_CROP) begin
			avg = src_pixel((line + `FB_CROP_YOFFSET) * 4096 + x + `FB_CROP_XOFFSET);
		end else begin
			a = src_pixel(2 * line * 4096 + 2 * x);
			b = src_pixel(2 * line * 4096 + 2 * x + 1);
			avg.red = 8'((int'(a.red) + int'(b.red)) / 2);
			avg.green = 8'((int'(a.green) + int'(b.green)) / 2);
			avg.blue = 8'((int'(a.blue) + int'(b.blue)) / 2);
		end
		return avg;
	endfunction

	// ######################################################################
	// AXI read slave and pixel checker
	// ######################################################################

	always @(posedge axi_clock) begin
		if (global_reset) begin
			arready <= 1'b0;
			r <= '0;
			burst_active = 1'b0;
			ar_delay = 0;
		end else begin
			if (ar.valid && arready) begin
				burst_q.push_back(ar.addr);
				arready <= 1'b0;
				ar_delay = stall_en ? int'(draw_bits(2)) : 0;
				if (exp_addr_q.size() == 0) begin
					abort_test($sformatf("%s: read address with no line pending", test_name));
				end else begin
					compare_addr(exp_addr_q.pop_front(), ar.addr);
				end
			end else if (ar.valid) begin
				if (ar_delay == 0) begin
					arready <= 1'b1;
				end else begin
					ar_delay--;
				end
			end
			r <= '0;
			if (!burst_active && burst_q.size() > 0) begin
				burst_addr = burst_q.pop_front();
				burst_active = 1'b1;
				beat_idx = 0;
			end
			if (burst_active) begin
				gap = stall_en && (draw_bits(2) == 4'd0);	// About one beat in four
				if (!gap) begin
					r <= '{valid: 1'b1, last: (beat_idx == `FB_BURST_LEN - 1),
						data: build_beat(burst_addr, beat_idx)};
					if (beat_idx == `FB_BURST_LEN - 1) begin
						burst_active = 1'b0;
						bursts_done <= bursts_done + 1;
					end
					beat_idx++;
				end
			end
		end
	end

	always @(posedge axi_clock) begin
		if (due_q.size() > 0 && due_q[0] == cycle) begin
			void'(due_q.pop_front());
			if (pixels.valid !== 1'b1) begin
				abort_test($sformatf("%s: no pixel two cycles after pixel_den", test_name));
			end else if (exp_pix_q.size() == 0) begin
				abort_test($sformatf("%s: pixel with no expected value", test_name));
			end else begin
				compare_pixel(exp_pix_q.pop_front(), pixels.rgb);
			end
		end else if (pixels.valid === 1'b1) begin
			abort_test($sformatf("%s: pixel valid without a pixel_den", test_name));
		end
		if (pixel_den === 1'b1) begin
			due_q.push_back(cycle + 2);
		end
	end

	// ######################################################################
	// Stimulus
	// ######################################################################

	task automatic check_quiet(input string when);
		if (ar.valid !== 1'b0 || pixels.valid !== 1'b0) begin
			abort_test($sformatf("%s: ar valid or pixel valid high %s", test_name, when));
		end
	endtask

	task automatic wait_bursts(input int target);
		int waited;
		waited = 0;
		while (bursts_done < target && waited < FETCH_LIMIT) begin
			@(posedge axi_clock);
			waited++;
		end
		if (bursts_done < target) begin
			abort_test($sformatf("%s: line fetch did not finish in time", test_name));
		end
	endtask

	// Nothing may be fetched past the bottom line
	task automatic check_no_fetch(input int window);
		int waited;
		waited = 0;
		while (ar.valid !== 1'b1 && waited < window) begin
			@(posedge axi_clock);
			waited++;
		end
		if (ar.valid === 1'b1) begin
			abort_test($sformatf("%s: read issued for a line below the frame", test_name));
		end
	endtask

	task automatic show_line(input zoom_t z, input int line);
		for (int x = 0; x < `FB_OUTPUT_WIDTH; x++) begin
			@(posedge axi_clock);
			pixel_den <= 1'b1;
			exp_pix_q.push_back(ref_pixel(z, line, x));
		end
		@(posedge axi_clock);
		pixel_den <= 1'b0;
	endtask

	task automatic run_frame(input zoom_t z, input string name);
		int bursts;
		int target;
		int waited;
		test_name = name;
		bursts = ((z == ZOOM_CROP) ? 1 : 2) * `FB_OUTPUT_WIDTH / BURST_PIX;
		target = bursts_done;
		waited = 0;
		@(posedge axi_clock);
		zoom <= z;
		// Step 0 is frame_start; step k shows line k-1 and requests line k
		for (int k = 0; k <= `FB_OUTPUT_HEIGHT; k++) begin
			if (k < `FB_OUTPUT_HEIGHT) begin
				for (int b = 0; b < bursts; b++) begin
					exp_addr_q.push_back(ref_addr(z, k, b));
				end
				target += bursts;
			end
			@(posedge axi_clock);
			frame_start <= (k == 0);
			line_start <= (k != 0);
			@(posedge axi_clock);
			frame_start <= 1'b0;
			line_start <= 1'b0;
			if (k == `FB_OUTPUT_HEIGHT) begin
				check_no_fetch(32);
			end
			if (k > 0) begin
				show_line(z, k - 1);
			end
			wait_bursts(target);
		end
		while (exp_pix_q.size() > 0 && waited < 16) begin
			@(posedge axi_clock);
			waited++;
		end
		if (exp_pix_q.size() > 0) begin
			abort_test($sformatf("%s: pixels missing at the end of the frame", test_name));
		end
	endtask

	initial begin
		global_reset = 1'b1;
		frame_start = 1'b0;
		line_start = 1'b0;
		pixel_den = 1'b0;
		zoom = ZOOM_CROP;
		for (int i = 0; i < 5; i++) begin
			@(posedge axi_clock);
			if (i > 0) begin
				check_quiet("during reset");	// Outputs undefined before the first edge
			end
		end
		global_reset <= 1'b0;
		repeat (3) begin
			@(posedge axi_clock);
			check_quiet("after reset");
		end
		run_frame(ZOOM_CROP, "crop frame");
		run_frame(ZOOM_SCALE, "scale frame");
		@(posedge axi_clock);
		stall_en <= 1'b1;
		run_frame(ZOOM_CROP, "crop frame with stalls");
		run_frame(ZOOM_SCALE, "scale frame with stalls");
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== fb_readout.f ====
+incdir+design
design/fb_readout_pkg.sv
design/line_fetcher.sv
design/line_buffer.sv
design/pixel_scanout.sv
design/fb_readout.sv
test/fb_readout_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the frame-buffer readout testbench with Verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fb_readout_tb -f fb_readout.f

# A $fatal gives a non-zero exit; the log decides the result
./obj_dir/Vfb_readout_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
